// File: Makefile
# Verilator build and run of the VC router testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := tb_vc_router
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail when the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: compile.f
+incdir+verilog
+incdir+sim
verilog/router_pkg.sv
verilog/flit_fifo.sv
verilog/vc_input_port.sv
verilog/switch_allocator.sv
verilog/output_credit_tracker.sv
verilog/switch_traversal.sv
verilog/vc_router.sv
sim/tb_vc_router.sv

// File: sim/router_tb_tasks.svh
// directed router tests, their stimulus helpers and checks
// payload carries source port, VC and a sequence number

  function automatic int flow_idx(input int src, input int vc, input int dst);
    return (src * V + vc) * P + dst;
  endfunction

  // credits the upstream sender still holds
  function automatic int up_credits(input int p, input int v);
    return `ROUTER_VC_DEPTH - sent[p][v] + cred_rx[p][v];
  endfunction

  function automatic bit router_idle();
    int n;
    n = 0;
    for (int o = 0; o < P; o++) begin
      n += rx_n[o];
      for (int v = 0; v < V; v++) begin
        if (ret_cnt[o][v] != rx_cnt[o][v]) begin
          return 1'b0;
        end
      end
    end
    return (n == tx_total);
  endfunction

  task automatic stop_input();
    @(posedge clk);
    in_flit_v <= '0;
  endtask

  // waits an edge and an upstream credit before presenting one flit
  task automatic send_flit(input int src, input int dst, input int vc);
    flit_t f;
    int    k;
    stop_input();
    while (up_credits(src, vc) == 0) begin
      @(posedge clk);
    end
    f.hdr.dst_port = port_id_t'(dst);
    f.hdr.vc_id    = vc_id_t'(vc);
    f.payload      = {8'(src), 8'(vc), 16'(seq)};
    k = flow_idx(src, vc, dst);
    tx_log[k][tx_n[k]] = f;
    tx_n[k]++;
    tx_total++;
    sent[src][vc]++;
    seq++;
    in_flit[src]   <= f;
    in_flit_v[src] <= 1'b1;
    sample_edge = cyc + 2;
  endtask

  // every arrival must be the oldest unmatched flit of its flow
  task automatic check_outputs();
    flit_t f;
    int    k;
    for (int o = 0; o < P; o++) begin
      while (rx_rd[o] < rx_n[o]) begin
        f = rx_log[o][rx_rd[o]];
        rx_rd[o]++;
        k = flow_idx(int'(f.payload[25:24]), int'(f.payload[16]), o);
        if (exp_rd[k] == tx_n[k]) begin
          $display("%s: output %0d delivered a flit nobody sent: %h", test_name, o, f);
          err_cnt++;
        end else begin
          if (f !== tx_log[k][exp_rd[k]]) begin
            $display("[FAIL] %s output %0d expected %h actual %h",
                     test_name, o, tx_log[k][exp_rd[k]], f);
            err_cnt++;
          end
          exp_rd[k]++;
        end
      end
    end
  endtask

  task automatic drain();
    stop_input();
    while (!router_idle()) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    check_outputs();
  endtask

  task automatic end_test(input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", test_name);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", test_name, err_cnt - errs_before);
    end
  endtask

  task automatic single_flit_latency();
    int errs;
    int cred0;
    errs = err_cnt;
    test_name = "single_flit_latency";
    cred0 = cred_rx[0][1];
    send_flit(0, 2, 1);
    drain();
    if (rx_edge[2][rx_n[2]-1] - sample_edge != 2) begin
      $display("[FAIL] %s latency expected 2 actual %0d",
               test_name, rx_edge[2][rx_n[2]-1] - sample_edge);
      err_cnt++;
    end
    if (cred_rx[0][1] - cred0 != 1) begin
      $display("[FAIL] %s port 0 vc 1 credits expected 1 actual %0d",
               test_name, cred_rx[0][1] - cred0);
      err_cnt++;
    end
    end_test(errs);
  endtask

  task automatic all_to_all();
    int errs;
    int src;
    int dst;
    int vc;
    errs = err_cnt;
    test_name = "all_to_all";
    repeat (48) begin
      src = int'($urandom % P);
      dst = int'($urandom % P);
      vc  = int'($urandom % V);
      send_flit(src, dst, vc);
    end
    drain();
    end_test(errs);
  endtask

  task automatic credit_accounting();
    int errs;
    errs = err_cnt;
    test_name = "credit_accounting";
    for (int p = 0; p < P; p++) begin
      for (int i = 0; i < 2 * V; i++) begin
        send_flit(p, (p + 1) % P, i % V);
      end
    end
    drain();
    for (int p = 0; p < P; p++) begin
      for (int v = 0; v < V; v++) begin
        if (cred_rx[p][v] != sent[p][v] || up_credits(p, v) != `ROUTER_VC_DEPTH) begin
          $display("[FAIL] %s port %0d vc %0d credits expected %0d actual %0d",
                   test_name, p, v, sent[p][v], cred_rx[p][v]);
          err_cnt++;
        end
      end
    end
    end_test(errs);
  endtask

  // output 0 gets no credit back, so it stops after one buffer per VC
  task automatic back_pressure();
    int errs;
    int base [V];
    errs = err_cnt;
    test_name = "back_pressure";
    for (int v = 0; v < V; v++) begin
      base[v] = rx_cnt[0][v];
    end
    ds_block[0][0] <= 1'b1;
    ds_block[0][1] <= 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_flit(1 + i % 2, 0, (i / 2) % 2);
    end
    stop_input();
    repeat (20) @(posedge clk);
    for (int v = 0; v < V; v++) begin
      if (rx_cnt[0][v] - base[v] != `ROUTER_VC_DEPTH) begin
        $display("[FAIL] %s vc %0d flits out while blocked expected %0d actual %0d",
                 test_name, v, `ROUTER_VC_DEPTH, rx_cnt[0][v] - base[v]);
        err_cnt++;
      end
    end
    ds_block[0][0] <= 1'b0;
    ds_block[0][1] <= 1'b0;
    drain();
    end_test(errs);
  endtask

  // input 0 uses up the credits before inputs 1 and 2 queue on the same VC
  // round robin then resumes one past input 0
  task automatic rr_fairness();
    int errs;
    int base;
    int src;
    int exp_src;
    errs = err_cnt;
    test_name = "rr_fairness";
    base = rx_n[3];
    ds_block[3][0] <= 1'b1;
    repeat (4) send_flit(0, 3, 0);
    for (int i = 0; i < 8; i++) begin
      send_flit(1 + i % 2, 3, 0);
    end
    stop_input();
    repeat (10) @(posedge clk);
    ds_block[3][0] <= 1'b0;
    drain();
    for (int i = 0; i < 12; i++) begin
      exp_src = (i < 4) ? 0 : 1 + i % 2;
      src     = int'(rx_log[3][base + i].payload[25:24]);
      if (src != exp_src) begin
        $display("[FAIL] %s flit %0d source expected %0d actual %0d",
                 test_name, i, exp_src, src);
        err_cnt++;
      end
    end
    end_test(errs);
  endtask

  // VC 1 flits pass the VC 0 flits of output 1 that have no credit
  task automatic vc_independence();
    int errs;
    int base;
    errs = err_cnt;
    test_name = "vc_independence";
    base = rx_n[1];
    ds_block[1][0] <= 1'b1;
    repeat (`ROUTER_VC_DEPTH + 2) send_flit(2, 1, 0);
    repeat (3) send_flit(2, 1, 1);
    stop_input();
    repeat (12) @(posedge clk);
    if (rx_n[1] - base != `ROUTER_VC_DEPTH + 3) begin
      $display("[FAIL] %s flits out while vc 0 blocked expected %0d actual %0d",
               test_name, `ROUTER_VC_DEPTH + 3, rx_n[1] - base);
      err_cnt++;
    end
    ds_block[1][0] <= 1'b0;
    drain();
    end_test(errs);
  endtask

// File: sim/tb_vc_router.sv
// testbench top for the four port VC router
// clock and reset, DUT, upstream and downstream credit models
// output monitor, watchdog and the directed test sequence

`timescale 1ns/10ps
`include "router_defines.svh"

module tb_vc_router;

  import router_pkg::*;

  localparam int P = `ROUTER_NUM_PORTS;
  localparam int V = `ROUTER_NUM_VC;
  localparam int NFLOW = P * V * P;
  localparam int CLK_NS = 8;
  // flits sent over the whole run, and a worst-case wait for each
  localparam int FLIT_COUNT = 98;
  localparam int FLIT_WORST_CYC = 40;
  localparam int TIMEOUT_NS = (FLIT_COUNT * FLIT_WORST_CYC + 200) * CLK_NS;

  logic              clk = 1'b0;
  logic              rst_n;
  logic [P-1:0]      in_flit_v;
  flit_t [P-1:0]     in_flit;
  credit_t [P-1:0]   credit;
  logic [P-1:0]      out_flit_v;
  flit_t [P-1:0]     out_flit;
  credit_t [P-1:0]   out_credit = '0;

  int    cyc = 0;
  int    err_cnt = 0;
  int    test_cnt = 0;
  int    test_fail = 0;
  int    seq = 0;
  int    sample_edge = 0;
  int    tx_total = 0;
  string test_name;

  // upstream side, flits sent and credits seen per input port and VC
  int    sent [P][V];
  int    cred_rx [P][V];
  // downstream side, flits taken and credits handed back per output and VC
  int    rx_cnt [P][V];
  int    ret_cnt [P][V];
  bit    ds_block [P][V];
  // arrivals per output, with the edge where each was taken
  flit_t rx_log [P][256];
  int    rx_edge [P][256];
  int    rx_n [P];
  int    rx_rd [P];
  // expected flits per source, VC and destination, in send order
  flit_t tx_log [NFLOW][128];
  int    tx_n [NFLOW];
  int    exp_rd [NFLOW];

  vc_router dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .in_flit_v_i  (in_flit_v),
    .in_flit_i    (in_flit),
    .credit_o     (credit),
    .out_flit_v_o (out_flit_v),
    .out_flit_o   (out_flit),
    .out_credit_i (out_credit)
  );

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // outputs and credit pulses are settled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      for (int o = 0; o < P; o++) begin
        if (out_flit_v[o]) begin
          rx_log[o][rx_n[o]] = out_flit[o];
          rx_edge[o][rx_n[o]] = cyc + 1;
          rx_n[o]++;
          rx_cnt[o][out_flit[o].hdr.vc_id]++;
        end
      end
      for (int p = 0; p < P; p++) begin
        if (credit[p].valid) begin
          cred_rx[p][credit[p].vc_id]++;
        end
      end
    end
  end

  // downstream frees one entry per output per cycle unless that VC is held
  always @(posedge clk) begin
    credit_t c;
    for (int o = 0; o < P; o++) begin
      c = '0;
      for (int v = 0; v < V; v++) begin
        if (!c.valid && rx_cnt[o][v] > ret_cnt[o][v] && !ds_block[o][v]) begin
          c.valid = 1'b1;
          c.vc_id = vc_id_t'(v);
        end
      end
      if (c.valid) begin
        ret_cnt[o][c.vc_id] <= ret_cnt[o][c.vc_id] + 1;
      end
      out_credit[o] <= c;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run still busy after %0d ns, router or testbench stalled", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  `include "router_tb_tasks.svh"

  initial begin
    void'($urandom(29));
    rst_n = 1'b0;
    in_flit_v = '0;
    in_flit = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    single_flit_latency();
    all_to_all();
    credit_accounting();
    back_pressure();
    rr_fairness();
    vc_independence();
    $display("summary: %0d tests, %0d failed, %0d check errors", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/flit_fifo.sv
// flit_fifo: circular buffer with a fall-through head
// element type is a parameter, so one module holds headers or payloads

`timescale 1ns/10ps

module flit_fifo #(
  parameter type elem_t = logic,
  parameter int  DEPTH  = 4
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  elem_t data_i,
  input  logic  pop_i,
  output elem_t data_o,
  output logic  valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  elem_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  // wrap by compare so DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = ptr + 1'b1;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end
    return nxt;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty   = (count_q == '0);
  // a full FIFO still takes a push when the head leaves in the same cycle
  assign do_push = push_i && (!full || pop_i);
  assign do_pop  = pop_i && !empty;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign data_o  = mem[rd_ptr_q];
  assign valid_o = !empty;

  // upstream sent without a credit
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (!full || pop_i))
    else $error("flit_fifo: push while full");

  // allocator popped a VC that had no head
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty)
    else $error("flit_fifo: pop while empty");

endmodule

// File: verilog/output_credit_tracker.sv
// output_credit_tracker: credit counters per output and VC
// grants take a credit, downstream credit pulses give one back

`timescale 1ns/10ps
`include "router_defines.svh"

module output_credit_tracker (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  router_pkg::xbar_sel_t [`ROUTER_NUM_PORTS-1:0]     sel_i,
  input  router_pkg::credit_t [`ROUTER_NUM_PORTS-1:0]       out_credit_i,
  output logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]  credit_avail_o
);

  import router_pkg::*;

  for (genvar o = 0; o < `ROUTER_NUM_PORTS; o++) begin : gen_out
    for (genvar v = 0; v < `ROUTER_NUM_VC; v++) begin : gen_vc

      credit_cnt_t cnt_q;
      logic        dec;
      logic        inc;

      assign dec = sel_i[o].valid && (sel_i[o].vc_id == vc_id_t'(v));
      assign inc = out_credit_i[o].valid && (out_credit_i[o].vc_id == vc_id_t'(v));

      // downstream buffer starts empty, so every entry is a credit
      always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
          cnt_q <= credit_cnt_t'(`ROUTER_VC_DEPTH);
        end else if (inc && !dec) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (dec && !inc) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end

      assign credit_avail_o[o][v] = (cnt_q != '0);

      // allocator only grants on an available credit
      a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec |-> (cnt_q != '0))
        else $error("credit tracker: underflow on output %0d vc %0d", o, v);

      // downstream returned more credits than it has entries
      a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (inc && !dec) |-> (cnt_q < credit_cnt_t'(`ROUTER_VC_DEPTH)))
        else $error("credit tracker: overflow on output %0d vc %0d", o, v);

    end
  end

endmodule

// File: verilog/router_defines.svh
// router configuration macros
// port count, VCs per port, VC FIFO depth and payload width

`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// number of router ports
`define ROUTER_NUM_PORTS 4

// virtual channels per port
`define ROUTER_NUM_VC 2

// entries per VC FIFO, also the reset credit count downstream
`define ROUTER_VC_DEPTH 4

// flit payload width in bits
`define ROUTER_DATA_W 32

`endif

// File: verilog/router_pkg.sv
// router types
// index types, header, flit, credit, crossbar select and credit counter

`include "router_defines.svh"

package router_pkg;

  typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] port_id_t;
  typedef logic [$clog2(`ROUTER_NUM_VC)-1:0]    vc_id_t;

  // source routed, so the header names the output directly
  typedef struct packed {
    port_id_t dst_port;
    vc_id_t   vc_id;
  } hdr_t;

  typedef logic [`ROUTER_DATA_W-1:0] payload_t;

  // header sits above the payload
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

  // one pulse frees one entry on vc_id
  typedef struct packed {
    logic   valid;
    vc_id_t vc_id;
  } credit_t;

  typedef struct packed {
    logic     valid;
    port_id_t src_port;
    vc_id_t   vc_id;
  } xbar_sel_t;

  typedef logic [$clog2(`ROUTER_VC_DEPTH + 1)-1:0] credit_cnt_t;

endpackage

// File: verilog/switch_allocator.sv
// switch_allocator: two-stage round-robin switch allocation
// stage one picks a VC per input, stage two an input per output
// a VC only requests when its output VC has a credit

`timescale 1ns/10ps
`include "router_defines.svh"

module switch_allocator (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]          head_v_i,
  input  router_pkg::hdr_t [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0] head_hdr_i,
  input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]          credit_avail_i,
  output logic [`ROUTER_NUM_PORTS-1:0]                              pop_v_o,
  output router_pkg::vc_id_t [`ROUTER_NUM_PORTS-1:0]                pop_vc_o,
  output router_pkg::xbar_sel_t [`ROUTER_NUM_PORTS-1:0]             sel_o
);

  import router_pkg::*;

  localparam int P = `ROUTER_NUM_PORTS;
  localparam int V = `ROUTER_NUM_VC;

  logic [P-1:0]     in_req_v;
  vc_id_t [P-1:0]   in_req_vc;
  port_id_t [P-1:0] in_req_dst;
  vc_id_t [P-1:0]   vc_ptr_q;
  port_id_t [P-1:0] out_ptr_q;

  // stage one, first eligible VC at or after the input's pointer
  always_comb begin
    int   v;
    hdr_t hdr;
    in_req_v   = '0;
    in_req_vc  = '0;
    in_req_dst = '0;
    for (int i = 0; i < P; i++) begin
      for (int k = 0; k < V; k++) begin
        v   = (int'(vc_ptr_q[i]) + k) % V;
        hdr = head_hdr_i[i][v];
        if (!in_req_v[i] && head_v_i[i][v] &&
            credit_avail_i[hdr.dst_port][hdr.vc_id]) begin
          in_req_v[i]   = 1'b1;
          in_req_vc[i]  = hdr.vc_id;
          in_req_dst[i] = hdr.dst_port;
        end
      end
    end
  end

  // stage two, first requesting input at or after the output's pointer
  always_comb begin
    int src;
    sel_o = '0;
    for (int o = 0; o < P; o++) begin
      for (int k = 0; k < P; k++) begin
        src = (int'(out_ptr_q[o]) + k) % P;
        if (!sel_o[o].valid && in_req_v[src] && in_req_dst[src] == port_id_t'(o)) begin
          sel_o[o].valid    = 1'b1;
          sel_o[o].src_port = port_id_t'(src);
          sel_o[o].vc_id    = in_req_vc[src];
        end
      end
    end
  end

  // an input requests one output, so it gets at most one grant
  always_comb begin
    pop_v_o = '0;
    for (int o = 0; o < P; o++) begin
      if (sel_o[o].valid) begin
        pop_v_o[sel_o[o].src_port] = 1'b1;
      end
    end
  end

  assign pop_vc_o = in_req_vc;

  // pointers move one past the winner, only on a grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vc_ptr_q  <= '0;
      out_ptr_q <= '0;
    end else begin
      for (int i = 0; i < P; i++) begin
        if (pop_v_o[i]) begin
          vc_ptr_q[i] <= vc_id_t'((int'(in_req_vc[i]) + 1) % V);
        end
      end
      for (int o = 0; o < P; o++) begin
        if (sel_o[o].valid) begin
          out_ptr_q[o] <= port_id_t'((int'(sel_o[o].src_port) + 1) % P);
        end
      end
    end
  end

  // granted head must really be headed for this output
  for (genvar o = 0; o < P; o++) begin : gen_chk
    a_gnt_matches_dst : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      sel_o[o].valid |->
        (head_v_i[sel_o[o].src_port][sel_o[o].vc_id] &&
         head_hdr_i[sel_o[o].src_port][sel_o[o].vc_id].dst_port == port_id_t'(o)))
      else $error("switch_allocator: output %0d granted a foreign request", o);
  end

endmodule

// File: verilog/switch_traversal.sv
// switch_traversal: crossbar driven by the allocator's selections
// registered flit and valid on every output port

`timescale 1ns/10ps
`include "router_defines.svh"

module switch_traversal (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  router_pkg::xbar_sel_t [`ROUTER_NUM_PORTS-1:0]                 sel_i,
  input  router_pkg::hdr_t [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]  head_hdr_i,
  input  router_pkg::payload_t [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0] head_payload_i,
  output logic [`ROUTER_NUM_PORTS-1:0]                                  out_flit_v_o,
  output router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]                     out_flit_o
);

  import router_pkg::*;

  flit_t [`ROUTER_NUM_PORTS-1:0] xbar_flit;

  // mux the selected input and VC head into a flit
  always_comb begin
    for (int o = 0; o < `ROUTER_NUM_PORTS; o++) begin
      xbar_flit[o].hdr     = head_hdr_i[sel_i[o].src_port][sel_i[o].vc_id];
      xbar_flit[o].payload = head_payload_i[sel_i[o].src_port][sel_i[o].vc_id];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_flit_v_o <= '0;
    end else begin
      for (int o = 0; o < `ROUTER_NUM_PORTS; o++) begin
        out_flit_v_o[o] <= sel_i[o].valid;
      end
    end
  end

  // flit register only loads on a grant
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `ROUTER_NUM_PORTS; o++) begin
      if (sel_i[o].valid) begin
        out_flit_o[o] <= xbar_flit[o];
      end
    end
  end

endmodule

// File: verilog/vc_input_port.sv
// vc_input_port: VC decode into per-VC header and payload FIFOs
// offers the head of every VC and returns a credit on each pop

`timescale 1ns/10ps
`include "router_defines.svh"

module vc_input_port (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       in_flit_v_i,
  input  router_pkg::flit_t                          in_flit_i,
  output logic [`ROUTER_NUM_VC-1:0]                  head_v_o,
  output router_pkg::hdr_t [`ROUTER_NUM_VC-1:0]      head_hdr_o,
  output router_pkg::payload_t [`ROUTER_NUM_VC-1:0]  head_payload_o,
  input  logic                                       pop_v_i,
  input  router_pkg::vc_id_t                         pop_vc_i,
  output router_pkg::credit_t                        credit_o
);

  import router_pkg::*;

  logic [`ROUTER_NUM_VC-1:0] push_oh;
  logic [`ROUTER_NUM_VC-1:0] pop_oh;
  logic [`ROUTER_NUM_VC-1:0] payload_v;

  // incoming flit goes to the FIFO pair named by its header
  always_comb begin
    push_oh = '0;
    if (in_flit_v_i) begin
      push_oh[in_flit_i.hdr.vc_id] = 1'b1;
    end
  end

  // switch allocation and traversal share this single pop
  always_comb begin
    pop_oh = '0;
    if (pop_v_i) begin
      pop_oh[pop_vc_i] = 1'b1;
    end
  end

  for (genvar v = 0; v < `ROUTER_NUM_VC; v++) begin : gen_vc

    flit_fifo #(
      .elem_t (hdr_t),
      .DEPTH  (`ROUTER_VC_DEPTH)
    ) u_hdr_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_oh[v]),
      .data_i  (in_flit_i.hdr),
      .pop_i   (pop_oh[v]),
      .data_o  (head_hdr_o[v]),
      .valid_o (head_v_o[v])
    );

    flit_fifo #(
      .elem_t (payload_t),
      .DEPTH  (`ROUTER_VC_DEPTH)
    ) u_payload_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_oh[v]),
      .data_i  (in_flit_i.payload),
      .pop_i   (pop_oh[v]),
      .data_o  (head_payload_o[v]),
      .valid_o (payload_v[v])
    );

    // header and payload of a flit move together
    a_pair_in_step : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      head_v_o[v] == payload_v[v])
      else $error("vc_input_port: header and payload FIFO out of step");

  end

  // one freed entry per pop, on the popped VC
  assign credit_o.valid = pop_v_i;
  assign credit_o.vc_id = pop_vc_i;

endmodule

// File: verilog/vc_router.sv
// vc_router: four port, two VC credit-based router top level
// input ports, switch allocator, output credit tracker and switch traversal

`timescale 1ns/10ps
`include "router_defines.svh"

module vc_router (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]                 in_flit_v_i,
  input  router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]    in_flit_i,
  output router_pkg::credit_t [`ROUTER_NUM_PORTS-1:0]  credit_o,
  output logic [`ROUTER_NUM_PORTS-1:0]                 out_flit_v_o,
  output router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]    out_flit_o,
  input  router_pkg::credit_t [`ROUTER_NUM_PORTS-1:0]  out_credit_i
);

  import router_pkg::*;

  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]     head_v;
  hdr_t [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]     head_hdr;
  payload_t [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0] head_payload;
  logic [`ROUTER_NUM_PORTS-1:0]                         pop_v;
  vc_id_t [`ROUTER_NUM_PORTS-1:0]                       pop_vc;
  xbar_sel_t [`ROUTER_NUM_PORTS-1:0]                    sel;
  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_VC-1:0]     credit_avail;

  for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : gen_in_port
    vc_input_port u_in_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .in_flit_v_i    (in_flit_v_i[p]),
      .in_flit_i      (in_flit_i[p]),
      .head_v_o       (head_v[p]),
      .head_hdr_o     (head_hdr[p]),
      .head_payload_o (head_payload[p]),
      .pop_v_i        (pop_v[p]),
      .pop_vc_i       (pop_vc[p]),
      .credit_o       (credit_o[p])
    );
  end

  switch_allocator u_sw_alloc (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .head_v_i       (head_v),
    .head_hdr_i     (head_hdr),
    .credit_avail_i (credit_avail),
    .pop_v_o        (pop_v),
    .pop_vc_o       (pop_vc),
    .sel_o          (sel)
  );

  output_credit_tracker u_credit_trk (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .sel_i          (sel),
    .out_credit_i   (out_credit_i),
    .credit_avail_o (credit_avail)
  );

  switch_traversal u_sw_trav (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .sel_i          (sel),
    .head_hdr_i     (head_hdr),
    .head_payload_i (head_payload),
    .out_flit_v_o   (out_flit_v_o),
    .out_flit_o     (out_flit_o)
  );

endmodule
